/* logic/apb_tpu_regs.sv */
// APB slave for the tpu: space decode, command register, status and result readback
`timescale 1ns/1ps

module apb_tpu_regs #(
    parameter int ARRAY_DIM = 4,
    parameter int MEM_DEPTH = 16,
    localparam int AW = $clog2(MEM_DEPTH)
) (
    input  logic                              clk,
    input  logic                              rst,
    input  logic                              psel,
    input  logic                              penable,
    input  logic                              pwrite,
    input  logic [11:0]                       paddr,
    input  logic [31:0]                       pwdata,
    input  logic                              busy,
    input  logic                              weights_ready,
    input  logic                              mult_done,
    input  tpu_pkg::acc_t [ARRAY_DIM-1:0]     out_rdata,
    output logic [31:0]                       prdata,
    output logic                              pready,
    output logic                              pslverr,
    output logic                              in_wr_en,
    output logic                              wt_wr_en,
    output logic [AW-1:0]                     mem_wr_addr,
    output tpu_pkg::operand_t [ARRAY_DIM-1:0] mem_wr_data,
    output logic [AW-1:0]                     out_rd_addr,
    output logic                              cmd_start,
    output logic [3:0]                        cmd_code,
    output logic [AW-1:0]                     base_a,
    output logic [AW-1:0]                     base_out,
    output logic [AW-1:0]                     row_last
);

    localparam int CW = $clog2(ARRAY_DIM);

    logic [1:0]    space;
    logic          setup;
    logic          access;
    logic          op_space;
    logic          cmd_wr;
    logic          code_ok;
    logic          cmd_bad;
    logic          cmd_error;
    logic [CW-1:0] col_q;
    logic [31:0]   status;

    // ==================================================
    // decode
    // ==================================================

    assign space    = paddr[11:10];
    assign setup    = psel & ~penable;
    assign access   = psel & penable;
    assign op_space = (space == tpu_regs_pkg::SPACE_INPUT) |
                      (space == tpu_regs_pkg::SPACE_WEIGHT);
    assign cmd_wr   = access & pwrite & (space == tpu_regs_pkg::SPACE_CTRL) &
                      (paddr[9:2] == tpu_regs_pkg::REG_CMD);

    // operand writes stall while the sequencer reads the memories
    assign pready = access & ~(pwrite & op_space & busy);

    assign in_wr_en    = access & pwrite & ~busy & (space == tpu_regs_pkg::SPACE_INPUT);
    assign wt_wr_en    = access & pwrite & ~busy & (space == tpu_regs_pkg::SPACE_WEIGHT);
    assign mem_wr_addr = paddr[2 +: AW];
    // element 0 sits in the low byte
    assign mem_wr_data = pwdata[ARRAY_DIM*8-1:0];

    // output row from the address, column picked after the read
    assign out_rd_addr = paddr[2+CW +: AW];

    // ==================================================
    // command checks
    // ==================================================

    always_comb begin
        case (pwdata[3:0])
            tpu_regs_pkg::CMD_CLEAR,
            tpu_regs_pkg::CMD_LOAD_WEIGHTS,
            tpu_regs_pkg::CMD_MULTIPLY: code_ok = 1'b1;
            default: code_ok = 1'b0;
        endcase
    end

    // cmd_start counts as busy, busy rises a cycle later
    assign cmd_bad = busy | cmd_start | ~code_ok;
    assign pslverr = cmd_wr & cmd_bad;

    always_ff @(posedge clk) begin
        if (rst) begin
            cmd_start <= 1'b0;
            cmd_error <= 1'b0;
        end else begin
            cmd_start <= cmd_wr & ~cmd_bad;
            if (cmd_wr && cmd_bad) begin
                cmd_error <= 1'b1;
            end else if (cmd_wr && pwdata[3:0] == tpu_regs_pkg::CMD_CLEAR) begin
                cmd_error <= 1'b0;
            end
        end
    end

    // command fields, taken only from accepted commands
    always_ff @(posedge clk) begin
        if (cmd_wr && !cmd_bad) begin
            cmd_code <= pwdata[3:0];
            base_a   <= pwdata[4 +: AW];
            base_out <= pwdata[8 +: AW];
            row_last <= pwdata[12 +: AW];
        end
        // column index held from the setup cycle
        if (setup) begin
            col_q <= paddr[2 +: CW];
        end
    end

    // ==================================================
    // readback
    // ==================================================

    always_comb begin
        status = '0;
        status[tpu_regs_pkg::ST_BUSY]          = busy;
        status[tpu_regs_pkg::ST_WEIGHTS_READY] = weights_ready;
        status[tpu_regs_pkg::ST_MULT_DONE]     = mult_done;
        status[tpu_regs_pkg::ST_CMD_ERROR]     = cmd_error;
    end

    // operand spaces read back as zero
    always_comb begin
        prdata = '0;
        if (space == tpu_regs_pkg::SPACE_CTRL && paddr[9:2] == tpu_regs_pkg::REG_STATUS) begin
            prdata = status;
        end else if (space == tpu_regs_pkg::SPACE_OUTPUT) begin
            prdata = out_rdata[col_q];
        end
    end

endmodule

/* logic/systolic_array.sv */
// weight-stationary systolic array of MAC cells with input skew and output deskew
`timescale 1ns/1ps

module systolic_array #(
    parameter int ARRAY_DIM = 4
) (
    input  logic                              clk,
    input  logic                              rst,
    input  logic                              weight_shift,
    input  tpu_pkg::operand_t [ARRAY_DIM-1:0] weight_row,
    input  logic                              act_valid,
    input  tpu_pkg::operand_t [ARRAY_DIM-1:0] act_row,
    output tpu_pkg::acc_t [ARRAY_DIM-1:0]     result_row,
    output logic                              result_valid
);

    tpu_pkg::operand_t a_west  [ARRAY_DIM];
    tpu_pkg::operand_t a_in    [ARRAY_DIM][ARRAY_DIM];
    tpu_pkg::operand_t a_q     [ARRAY_DIM][ARRAY_DIM-1];
    tpu_pkg::operand_t w_in    [ARRAY_DIM][ARRAY_DIM];
    tpu_pkg::operand_t w_q     [ARRAY_DIM][ARRAY_DIM];
    tpu_pkg::acc_t     p_in    [ARRAY_DIM][ARRAY_DIM];
    tpu_pkg::acc_t     p_q     [ARRAY_DIM][ARRAY_DIM];
    tpu_pkg::acc_t     col_out [ARRAY_DIM];
    logic [2*ARRAY_DIM-1:0] vld_q;

    // ==================================================
    // input skew, row r late by r cycles
    // ==================================================

    for (genvar r = 0; r < ARRAY_DIM; r++) begin : g_skew
        if (r == 0) begin : g_direct
            assign a_west[r] = act_row[r];
        end else begin : g_delay
            tpu_pkg::operand_t line_q [r];
            always_ff @(posedge clk) begin
                line_q[0] <= act_row[r];
                for (int s = 1; s < r; s++) begin
                    line_q[s] <= line_q[s-1];
                end
            end
            assign a_west[r] = line_q[r-1];
        end
    end

    // ==================================================
    // MAC grid
    // ==================================================

    for (genvar r = 0; r < ARRAY_DIM; r++) begin : g_row
        for (genvar c = 0; c < ARRAY_DIM; c++) begin : g_col
            // activations east
            if (c == 0) begin : g_west
                assign a_in[r][c] = a_west[r];
            end else begin : g_east
                assign a_in[r][c] = a_q[r][c-1];
            end
            // weights shift down, partial sums go south
            if (r == 0) begin : g_top
                assign w_in[r][c] = weight_row[c];
                assign p_in[r][c] = '0;
            end else begin : g_below
                assign w_in[r][c] = w_q[r-1][c];
                assign p_in[r][c] = p_q[r-1][c];
            end
            always_ff @(posedge clk) begin
                if (weight_shift) begin
                    w_q[r][c] <= w_in[r][c];
                end
                p_q[r][c] <= p_in[r][c] + a_in[r][c] * w_q[r][c];
            end
            // last column passes nothing on
            if (c < ARRAY_DIM - 1) begin : g_pass
                always_ff @(posedge clk) begin
                    a_q[r][c] <= a_in[r][c];
                end
            end
        end
    end

    // ==================================================
    // output deskew, column c late by ARRAY_DIM-1-c
    // ==================================================

    for (genvar c = 0; c < ARRAY_DIM; c++) begin : g_deskew
        if (c == ARRAY_DIM - 1) begin : g_direct
            assign col_out[c] = p_q[ARRAY_DIM-1][c];
        end else begin : g_delay
            tpu_pkg::acc_t line_q [ARRAY_DIM-1-c];
            always_ff @(posedge clk) begin
                line_q[0] <= p_q[ARRAY_DIM-1][c];
                for (int s = 1; s < ARRAY_DIM - 1 - c; s++) begin
                    line_q[s] <= line_q[s-1];
                end
            end
            assign col_out[c] = line_q[ARRAY_DIM-2-c];
        end
    end

    // all columns line up here, 2*ARRAY_DIM after act_valid
    always_ff @(posedge clk) begin
        for (int c = 0; c < ARRAY_DIM; c++) begin
            result_row[c] <= col_out[c];
        end
    end

    // valid pipe
    always_ff @(posedge clk) begin
        if (rst) begin
            vld_q <= '0;
        end else begin
            vld_q <= {vld_q[2*ARRAY_DIM-2:0], act_valid};
        end
    end

    assign result_valid = vld_q[2*ARRAY_DIM-1];

endmodule

/* logic/tile_memory.sv */
// row-wide tile memory, one write port and a registered read port
`timescale 1ns/1ps

module tile_memory #(
    parameter type row_t     = logic [31:0],
    parameter int  MEM_DEPTH = 16,
    localparam int AW = $clog2(MEM_DEPTH)
) (
    input  logic          clk,
    input  logic          wr_en,
    input  logic [AW-1:0] wr_addr,
    input  row_t          wr_data,
    input  logic [AW-1:0] rd_addr,
    output row_t          rd_data
);

    // one entry per row
    row_t mem [MEM_DEPTH];

    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_addr] <= wr_data;
        end
    end

    // data one cycle after the address
    always_ff @(posedge clk) begin
        rd_data <= mem[rd_addr];
    end

endmodule

/* logic/tpu_pkg.sv */
// tpu datapath package: operand and accumulator element types, array defaults

package tpu_pkg;

    // ==================================================
    // element types
    // ==================================================

    // signed 8-bit matrix operand
    typedef logic signed [7:0] operand_t;

    // signed 32-bit accumulator, also the result element
    typedef logic signed [31:0] acc_t;

    // ==================================================
    // defaults for the top level
    // ==================================================

    // array side, one weight tile is DEF_ARRAY_DIM x DEF_ARRAY_DIM
    localparam int DEF_ARRAY_DIM = 4;

    // rows held by each tile memory
    localparam int DEF_MEM_DEPTH = 16;

endpackage

/* logic/tpu_regs_pkg.sv */
// tpu register package: APB address spaces, command codes and status bits

package tpu_regs_pkg;

    // address space, held in paddr[11:10]
    localparam logic [1:0] SPACE_CTRL   = 2'd0;
    localparam logic [1:0] SPACE_INPUT  = 2'd1;
    localparam logic [1:0] SPACE_WEIGHT = 2'd2;
    localparam logic [1:0] SPACE_OUTPUT = 2'd3;

    // word offsets inside the control space, paddr[9:2]
    localparam logic [7:0] REG_CMD    = 8'd0;
    localparam logic [7:0] REG_STATUS = 8'd1;

    // command codes, cmd word bits 3:0
    localparam logic [3:0] CMD_CLEAR        = 4'hf;
    localparam logic [3:0] CMD_LOAD_WEIGHTS = 4'h1;
    localparam logic [3:0] CMD_MULTIPLY     = 4'h3;

    // status register bit positions
    localparam int ST_BUSY          = 0;
    localparam int ST_WEIGHTS_READY = 1;
    localparam int ST_MULT_DONE     = 2;
    localparam int ST_CMD_ERROR     = 3;

endpackage

/* logic/tpu_sequencer.sv */
// tpu sequencer: weight load and multiply FSM driving memories and array control
`timescale 1ns/1ps

module tpu_sequencer #(
    parameter int ARRAY_DIM = 4,
    parameter int MEM_DEPTH = 16,
    localparam int AW = $clog2(MEM_DEPTH)
) (
    input  logic          clk,
    input  logic          rst,
    input  logic          cmd_start,
    input  logic [3:0]    cmd_code,
    input  logic [AW-1:0] base_a,
    input  logic [AW-1:0] base_out,
    input  logic [AW-1:0] row_last,
    input  logic          result_valid,
    output logic [AW-1:0] in_rd_addr,
    output logic [AW-1:0] wt_rd_addr,
    output logic          weight_shift,
    output logic          act_valid,
    output logic          out_wr_en,
    output logic [AW-1:0] out_wr_addr,
    output logic          busy,
    output logic          weights_ready,
    output logic          mult_done
);

    typedef enum logic [1:0] {
        S_IDLE,
        S_LOAD,
        S_STREAM
    } state_t;

    state_t        state;
    logic [AW-1:0] rd_cnt;
    logic [AW-1:0] out_cnt;
    logic [AW-1:0] base_a_q;
    logic [AW-1:0] base_out_q;
    logic [AW-1:0] last_q;
    logic          feeding;

    // weight rows go in last first, row 0 ends at the top of the grid
    assign wt_rd_addr  = base_a_q + AW'(ARRAY_DIM - 1) - rd_cnt;
    assign in_rd_addr  = base_a_q + rd_cnt;
    assign out_wr_en   = result_valid & (state == S_STREAM);
    assign out_wr_addr = base_out_q + out_cnt;

    // ==================================================
    // FSM
    // ==================================================

    always_ff @(posedge clk) begin
        if (rst) begin
            state         <= S_IDLE;
            rd_cnt        <= '0;
            out_cnt       <= '0;
            feeding       <= 1'b0;
            weight_shift  <= 1'b0;
            act_valid     <= 1'b0;
            busy          <= 1'b0;
            weights_ready <= 1'b0;
            mult_done     <= 1'b0;
        end else begin
            // memory read is one cycle, strobes follow the address by one
            weight_shift <= (state == S_LOAD);
            act_valid    <= feeding;
            case (state)
                S_IDLE: begin
                    if (cmd_start) begin
                        rd_cnt  <= '0;
                        out_cnt <= '0;
                        case (cmd_code)
                            tpu_regs_pkg::CMD_LOAD_WEIGHTS: begin
                                state         <= S_LOAD;
                                busy          <= 1'b1;
                                weights_ready <= 1'b0;
                            end
                            tpu_regs_pkg::CMD_MULTIPLY: begin
                                state     <= S_STREAM;
                                busy      <= 1'b1;
                                feeding   <= 1'b1;
                                mult_done <= 1'b0;
                            end
                            tpu_regs_pkg::CMD_CLEAR: begin
                                weights_ready <= 1'b0;
                                mult_done     <= 1'b0;
                            end
                            default: begin
                            end
                        endcase
                    end
                end
                S_LOAD: begin
                    rd_cnt <= rd_cnt + 1'b1;
                    if (rd_cnt == AW'(ARRAY_DIM - 1)) begin
                        state         <= S_IDLE;
                        busy          <= 1'b0;
                        weights_ready <= 1'b1;
                    end
                end
                S_STREAM: begin
                    // one input row per cycle
                    if (feeding) begin
                        rd_cnt <= rd_cnt + 1'b1;
                        if (rd_cnt == last_q) begin
                            feeding <= 1'b0;
                        end
                    end
                    // done on the last result row written
                    if (result_valid) begin
                        out_cnt <= out_cnt + 1'b1;
                        if (out_cnt == last_q) begin
                            state     <= S_IDLE;
                            busy      <= 1'b0;
                            mult_done <= 1'b1;
                        end
                    end
                end
                default: state <= S_IDLE;
            endcase
        end
    end

    // bases held for the whole command
    always_ff @(posedge clk) begin
        if (state == S_IDLE && cmd_start) begin
            base_a_q   <= base_a;
            base_out_q <= base_out;
            last_q     <= row_last;
        end
    end

endmodule

/* logic/tpu_top.sv */
// tpu top level: APB register stage, tile memories, sequencer and systolic array
`timescale 1ns/1ps

module tpu_top #(
    parameter int ARRAY_DIM = tpu_pkg::DEF_ARRAY_DIM,
    parameter int MEM_DEPTH = tpu_pkg::DEF_MEM_DEPTH,
    localparam int AW = $clog2(MEM_DEPTH)
) (
    input  logic        clk,
    input  logic        rst,
    input  logic        psel,
    input  logic        penable,
    input  logic        pwrite,
    input  logic [11:0] paddr,
    input  logic [31:0] pwdata,
    output logic [31:0] prdata,
    output logic        pready,
    output logic        pslverr
);

    typedef tpu_pkg::operand_t [ARRAY_DIM-1:0] op_row_t;
    typedef tpu_pkg::acc_t [ARRAY_DIM-1:0]     acc_row_t;

    // bus stage to memories and sequencer
    logic          in_wr_en;
    logic          wt_wr_en;
    logic [AW-1:0] mem_wr_addr;
    op_row_t       mem_wr_data;
    logic [AW-1:0] out_rd_addr;
    acc_row_t      out_rdata;
    logic          cmd_start;
    logic [3:0]    cmd_code;
    logic [AW-1:0] base_a;
    logic [AW-1:0] base_out;
    logic [AW-1:0] row_last;

    // sequencer, array and memories
    logic [AW-1:0] in_rd_addr;
    logic [AW-1:0] wt_rd_addr;
    op_row_t       in_row;
    op_row_t       wt_row;
    logic          weight_shift;
    logic          act_valid;
    acc_row_t      result_row;
    logic          result_valid;
    logic          out_wr_en;
    logic [AW-1:0] out_wr_addr;
    logic          busy;
    logic          weights_ready;
    logic          mult_done;

    apb_tpu_regs #(.ARRAY_DIM(ARRAY_DIM), .MEM_DEPTH(MEM_DEPTH)) u_regs (
        .clk, .rst, .psel, .penable, .pwrite, .paddr, .pwdata,
        .busy, .weights_ready, .mult_done, .out_rdata,
        .prdata, .pready, .pslverr, .in_wr_en, .wt_wr_en, .mem_wr_addr, .mem_wr_data,
        .out_rd_addr, .cmd_start, .cmd_code, .base_a, .base_out, .row_last
    );

    tile_memory #(.row_t(op_row_t), .MEM_DEPTH(MEM_DEPTH)) u_input_mem (
        .clk, .wr_en(in_wr_en), .wr_addr(mem_wr_addr), .wr_data(mem_wr_data),
        .rd_addr(in_rd_addr), .rd_data(in_row)
    );

    tile_memory #(.row_t(op_row_t), .MEM_DEPTH(MEM_DEPTH)) u_weight_mem (
        .clk, .wr_en(wt_wr_en), .wr_addr(mem_wr_addr), .wr_data(mem_wr_data),
        .rd_addr(wt_rd_addr), .rd_data(wt_row)
    );

    tpu_sequencer #(.ARRAY_DIM(ARRAY_DIM), .MEM_DEPTH(MEM_DEPTH)) u_seq (
        .clk, .rst, .cmd_start, .cmd_code, .base_a, .base_out, .row_last, .result_valid,
        .in_rd_addr, .wt_rd_addr, .weight_shift, .act_valid, .out_wr_en, .out_wr_addr,
        .busy, .weights_ready, .mult_done
    );

    systolic_array #(.ARRAY_DIM(ARRAY_DIM)) u_array (
        .clk, .rst, .weight_shift, .weight_row(wt_row), .act_valid, .act_row(in_row),
        .result_row, .result_valid
    );

    tile_memory #(.row_t(acc_row_t), .MEM_DEPTH(MEM_DEPTH)) u_output_mem (
        .clk, .wr_en(out_wr_en), .wr_addr(out_wr_addr), .wr_data(result_row),
        .rd_addr(out_rd_addr), .rd_data(out_rdata)
    );

endmodule

/* run_sim.sh */
#!/bin/sh
# build the tpu testbench with Verilator, run it, and judge the log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing -Wno-fatal -f src.f --top-module tb_tpu -o tb_tpu > sim.log 2>&1 &&
    ./obj_dir/tb_tpu >> sim.log 2>&1 ||
    echo "build or run error" >> sim.log
cat sim.log
grep -q "^sim failed$" sim.log && exit 1
grep -q "^sim passed$" sim.log || exit 1
exit 0

/* src.f */
logic/tpu_pkg.sv
logic/tpu_regs_pkg.sv
logic/tile_memory.sv
logic/systolic_array.sv
logic/tpu_sequencer.sv
logic/apb_tpu_regs.sv
logic/tpu_top.sv
verif/tb_tpu.sv

/* verif/tb_tpu.sv */
// tpu testbench: APB driver replaying the golden command file against tpu_top
`timescale 1ns/1ps

module tb_tpu;

    localparam int PERIOD       = 100;
    localparam int XFER_TIMEOUT = 200;
    localparam int POLL_TIMEOUT = 100;

    // status register address in the control space
    localparam logic [11:0] STATUS_ADDR = {tpu_regs_pkg::SPACE_CTRL, tpu_regs_pkg::REG_STATUS,
                                           2'b00};

    logic        clk;
    logic        rst;
    logic        psel;
    logic        penable;
    logic        pwrite;
    logic [11:0] paddr;
    logic [31:0] pwdata;
    logic [31:0] prdata;
    logic        pready;
    logic        pslverr;

    int          errors;
    int          checks;
    logic        stop_run;
    logic [31:0] lfsr;

    tpu_top UUT (
        .clk, .rst, .psel, .penable, .pwrite, .paddr, .pwdata,
        .prdata, .pready, .pslverr
    );

    initial begin
        clk = 1'b0;
        forever begin
            #(PERIOD/2) clk = ~clk;
        end
    end

    // ==================================================
    // helpers
    // ==================================================

    // galois LFSR, right shift
    function automatic logic [31:0] lfsr_step(input logic [31:0] state);
        if (state[0]) begin
            return (state >> 1) ^ 32'hd000_0001;
        end else begin
            return state >> 1;
        end
    endfunction

    // 0 to 3 idle cycles, two LFSR bits
    task automatic idle_gap();
        logic [1:0] n;
        n = '0;
        for (int i = 0; i < 2; i++) begin
            n    = {n[0], lfsr[0]};
            lfsr = lfsr_step(lfsr);
        end
        repeat (n) @(negedge clk);
    endtask

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("FAILED %s: got %h, expected %h at %0t", name, actual, expected, $time);
        end
    endtask

    // one APB transfer, setup then access until pready
    task automatic apb_xfer(input logic write, input logic [11:0] addr, input logic [31:0] wdata,
                            output logic [31:0] rdata, output logic err);
        int waits;
        idle_gap();
        @(negedge clk);
        psel    = 1'b1;
        penable = 1'b0;
        pwrite  = write;
        paddr   = addr;
        pwdata  = wdata;
        @(negedge clk);
        penable = 1'b1;
        // look a quarter period after the drive edge, well before posedge
        #(PERIOD/4);
        waits = 0;
        while (!pready && waits < XFER_TIMEOUT) begin
            @(negedge clk);
            #(PERIOD/4);
            waits++;
        end
        rdata = prdata;
        err   = pslverr;
        if (!pready) begin
            $display("timeout: no pready after %0d cycles at address %h", waits, addr);
            errors++;
            stop_run = 1'b1;
        end
        // transfer ends on the posedge in between
        @(negedge clk);
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
    endtask

    // read status until all mask bits are set
    task automatic poll_status(input logic [31:0] mask);
        logic [31:0] status;
        logic        err;
        int          tries;
        tries = 0;
        apb_xfer(1'b0, STATUS_ADDR, '0, status, err);
        while ((status & mask) != mask && tries < POLL_TIMEOUT && !stop_run) begin
            apb_xfer(1'b0, STATUS_ADDR, '0, status, err);
            tries++;
        end
        if ((status & mask) != mask && !stop_run) begin
            $display("timeout: status bits %h never set, last status %h", mask, status);
            errors++;
            stop_run = 1'b1;
        end
    endtask

    // ==================================================
    // golden file interpreter
    // ==================================================

    task automatic run_golden();
        int             fd;
        int             n;
        logic [63:0]    kind;
        logic [31:0]    addr;
        logic [31:0]    value;
        logic [31:0]    rdata;
        logic           err;
        logic [2047:0]  rest;
        fd = $fopen("verif/tpu_golden.txt", "r");
        if (fd == 0) begin
            $display("cannot open the golden file verif/tpu_golden.txt");
            errors++;
            return;
        end
        n = $fscanf(fd, "%s", kind);
        while (n == 1 && !stop_run) begin
            case (kind)
                // comment, drop the rest of the line
                "#": n = $fgets(rest, fd);
                "W": begin
                    n = $fscanf(fd, "%h %h", addr, value);
                    apb_xfer(1'b1, addr[11:0], value, rdata, err);
                    check_value("pslverr", {31'd0, err}, 32'd0);
                end
                "E": begin
                    n = $fscanf(fd, "%h %h", addr, value);
                    apb_xfer(1'b1, addr[11:0], value, rdata, err);
                    check_value("pslverr", {31'd0, err}, 32'd1);
                end
                "R": begin
                    n = $fscanf(fd, "%h %h", addr, value);
                    apb_xfer(1'b0, addr[11:0], '0, rdata, err);
                    check_value("prdata", rdata, value);
                end
                "P": begin
                    n = $fscanf(fd, "%h", value);
                    poll_status(value);
                end
                default: begin
                    $display("unknown command in the golden file: %s", kind);
                    errors++;
                    stop_run = 1'b1;
                end
            endcase
            n = $fscanf(fd, "%s", kind);
        end
        $fclose(fd);
    endtask

    // ==================================================
    // main sequence
    // ==================================================

    initial begin
        rst      = 1'b1;
        psel     = 1'b0;
        penable  = 1'b0;
        pwrite   = 1'b0;
        paddr    = '0;
        pwdata   = '0;
        errors   = 0;
        checks   = 0;
        stop_run = 1'b0;
        lfsr     = 32'h6946e605;
        // three reset cycles, release on a falling edge
        repeat (3) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        run_golden();
        repeat (2) @(negedge clk);
        $display("%0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule

/* verif/tpu_golden.txt */
# columns: kind addr data, W write, R read and compare, E write expecting pslverr
# P mask polls the status register until the mask bits are set, values in hex
# reset state, status and operand spaces read zero
R 004 00000000
R 400 00000000
R 800 00000000
# weight tile rows 0 to 3, element 0 in the low byte
W 800 ff000201
W 804 02030100
W 808 010100fe
W 80c 0002ff01
W 000 00000001
P 2
R 004 00000002
# six input rows at base 0
W 400 00000001
W 404 00000100
W 408 01010101
W 40c fc0302ff
W 410 0a05807f
W 414 0207fbfd
R 414 00000000
# multiply rows 0 to 5 into output base 0
W 000 00005003
P 4
R 004 00000006
R c00 00000001
R c04 00000002
R c08 00000000
R c0c ffffffff
R c10 00000000
R c14 00000001
R c18 00000003
R c1c 00000002
R c20 00000000
R c24 00000002
R c28 00000006
R c2c 00000002
R c30 fffffff5
R c34 00000004
R c38 00000001
R c3c 00000008
R c40 0000007f
R c44 00000074
R c48 fffffe99
R c4c fffffe86
R c50 fffffff1
R c54 fffffff3
R c58 fffffffc
R c5c 00000000
# clear, then two rows from input base 8 into output base 8
W 000 0000000f
R 004 00000000
W 420 fd04ff02
W 424 29e2140a
W 000 00001883
P 4
R 004 00000004
R c80 fffffff7
R c84 00000006
R c88 fffffffb
R c8c 00000000
R c90 0000006f
R c94 ffffffff
R c98 00000070
R c9c 00000000
# earlier rows untouched
R c00 00000001
R c14 00000001
R c28 00000006
R c3c 00000008
R c40 0000007f
R c54 fffffff3
# command while busy and an unknown code
W 000 00005003
E 000 00000003
P 4
R 004 0000000c
E 000 00000007
R 004 0000000c
W 000 0000000f
R 004 00000000
# input write during a multiply waits for the end
W 000 00001c83
W 420 050003f9
R 004 00000004
R cc0 fffffff7
R cc4 00000006
R cc8 fffffffb
R ccc 00000000
R cd0 0000006f
R cd4 ffffffff
R cd8 00000070
R cdc 00000000
# multiply over the new row 8 into output row 14
W 000 00000e83
P 4
R ce0 fffffffe
R ce4 fffffff0
R ce8 00000013
R cec 0000000d
